// ==== src/fmpac_pkg.sv ====
package fmpac_pkg;

    localparam int PAGE_BITS = 14;  // Offset bits inside a 16 KB page
    localparam int SRAM_BITS = 13;  // 8 KB of SRAM per slot

    typedef logic [15:0]          cpu_addr_t;
    typedef logic [7:0]           cpu_data_t;
    typedef logic [15:0]          rom_addr_t;   // Bank on top of the page offset
    typedef logic [SRAM_BITS-1:0] sram_addr_t;
    typedef logic [1:0]           bank_t;

    // Mapper registers, as offsets inside page 1
    localparam logic [PAGE_BITS-1:0] REG_MAGIC_LO  = 14'h1FFE;
    localparam logic [PAGE_BITS-1:0] REG_MAGIC_HI  = 14'h1FFF;
    localparam logic [PAGE_BITS-1:0] REG_OPLL_ADDR = 14'h3FF4;
    localparam logic [PAGE_BITS-1:0] REG_OPLL_DATA = 14'h3FF5;
    localparam logic [PAGE_BITS-1:0] REG_ENABLE    = 14'h3FF6;
    localparam logic [PAGE_BITS-1:0] REG_BANK      = 14'h3FF7;

    localparam logic [15:0] SRAM_MAGIC  = 16'h694D;  // High byte then low byte
    localparam cpu_data_t   ENABLE_MASK = 8'h11;     // Bit 4 locks SRAM, bit 0 enables OPLL
    localparam cpu_data_t   OPEN_BUS    = 8'hFF;

    // Four-phase handshake of the bus slave
    typedef enum logic [1:0] {
        IDLE,     // Waiting for req
        ACCESS,   // Access strobe out to the mapper
        RESPOND,  // Memory or register data arriving
        RELEASE   // ack high until req drops
    } bus_state_t;

endpackage

// ==== src/cpu_bus_slave.sv ====
`timescale 1ns/100ps

module cpu_bus_slave
    import fmpac_pkg::*;
#(
    parameter int  NUM_SLOTS = 2,
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic              cpu_bus,
    input  logic              rst_n,
    input  logic              req,
    input  cpu_addr_t         addr,
    input  cpu_data_t         wdata,
    input  logic              wr,
    input  logic [SLOT_W-1:0] slot_id,
    input  cpu_data_t         mem_rdata,
    input  logic              mem_valid,
    input  cpu_data_t         reg_rdata,
    output logic              ack,
    output cpu_data_t         rdata,
    output logic              acc_stb,
    output cpu_addr_t         acc_addr,
    output cpu_data_t         acc_wdata,
    output logic              acc_wr,
    output logic [SLOT_W-1:0] acc_slot
);

    bus_state_t state;
    bus_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_nxt = ACCESS;
                end
            end
            ACCESS:  state_nxt = RESPOND;
            RESPOND: state_nxt = RELEASE;
            RELEASE: begin
                if (!req) begin  // Master let go, drop ack
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request is stable while req is high, capture once at acceptance
    always_ff @(posedge cpu_bus) begin
        if (state == IDLE && req) begin
            acc_addr  <= addr;
            acc_wdata <= wdata;
            acc_wr    <= wr;
            acc_slot  <= slot_id;
        end
    end

    // Memory data wins, otherwise the register value (open bus included)
    always_ff @(posedge cpu_bus) begin
        if (state == RESPOND) begin
            rdata <= mem_valid ? mem_rdata : reg_rdata;
        end
    end

    assign acc_stb = (state == ACCESS);
    assign ack     = (state == RELEASE);  // Rises two edges after req is taken

endmodule

// ==== src/fmpac_mapper.sv ====
`timescale 1ns/100ps

module fmpac_mapper
    import fmpac_pkg::*;
#(
    parameter int  NUM_SLOTS = 2,
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic              cpu_bus,
    input  logic              rst_n,
    input  logic              acc_stb,
    input  cpu_addr_t         acc_addr,
    input  cpu_data_t         acc_wdata,
    input  logic              acc_wr,
    input  logic [SLOT_W-1:0] acc_slot,
    output logic              rom_rd,
    output rom_addr_t         rom_addr,
    output logic              sram_rd,
    output logic              sram_wr,
    output sram_addr_t        sram_addr,
    output cpu_data_t         sram_wdata,
    output logic [SLOT_W-1:0] sram_slot,
    output logic              opll_addr_wr,
    output logic              opll_data_wr,
    output cpu_data_t         opll_value,
    output cpu_data_t         reg_rdata,
    output logic              mem_sel
);

    // Per-slot mapper state
    cpu_data_t enable   [NUM_SLOTS];
    bank_t     bank     [NUM_SLOTS];
    cpu_data_t magic_lo [NUM_SLOTS];
    cpu_data_t magic_hi [NUM_SLOTS];

    logic [PAGE_BITS-1:0] offset;
    logic                 page1;
    logic                 sram_open;
    logic                 sram_hit;
    logic                 hit_magic_lo;
    logic                 hit_magic_hi;
    logic                 reg_hit;
    logic                 rom_hit;
    logic                 cpu_write;
    cpu_data_t            rd_value;

    assign offset    = acc_addr[PAGE_BITS-1:0];
    assign page1     = (acc_addr[15:14] == 2'b01);  // 4000h to 7FFFh
    assign sram_open = ({magic_hi[acc_slot], magic_lo[acc_slot]} == SRAM_MAGIC);
    assign sram_hit  = page1 && sram_open && (offset < REG_MAGIC_LO);
    assign cpu_write = acc_stb && acc_wr && page1;

    assign hit_magic_lo = page1 && (offset == REG_MAGIC_LO);
    assign hit_magic_hi = page1 && (offset == REG_MAGIC_HI);

    // Magic bytes are only visible once SRAM is unlocked
    assign reg_hit = (page1 && (offset == REG_ENABLE || offset == REG_BANK))
                   || (sram_open && (hit_magic_lo || hit_magic_hi));
    assign rom_hit = page1 && !sram_hit && !reg_hit;

    assign rom_rd     = acc_stb && !acc_wr && rom_hit;
    assign rom_addr   = {bank[acc_slot], offset};
    assign sram_rd    = acc_stb && !acc_wr && sram_hit;
    assign sram_wr    = acc_stb && acc_wr && sram_hit;
    assign sram_addr  = offset[SRAM_BITS-1:0];
    assign sram_wdata = acc_wdata;
    assign sram_slot  = acc_slot;

    // OPLL writes pass only with enable bit 0 set
    assign opll_addr_wr = cpu_write && enable[acc_slot][0] && (offset == REG_OPLL_ADDR);
    assign opll_data_wr = cpu_write && enable[acc_slot][0] && (offset == REG_OPLL_DATA);
    assign opll_value   = acc_wdata;

    always_comb begin
        rd_value = OPEN_BUS;
        if (page1 && offset == REG_ENABLE) begin
            rd_value = enable[acc_slot];
        end else if (page1 && offset == REG_BANK) begin
            rd_value = {6'b000000, bank[acc_slot]};
        end else if (sram_open && hit_magic_lo) begin
            rd_value = magic_lo[acc_slot];
        end else if (sram_open && hit_magic_hi) begin
            rd_value = magic_hi[acc_slot];
        end
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                enable[i]   <= '0;
                bank[i]     <= '0;
                magic_lo[i] <= '0;
                magic_hi[i] <= '0;
            end
        end else if (cpu_write) begin
            case (offset)
                REG_MAGIC_LO: begin
                    if (!enable[acc_slot][4]) begin  // Locked while bit 4 is set
                        magic_lo[acc_slot] <= acc_wdata;
                    end
                end
                REG_MAGIC_HI: begin
                    if (!enable[acc_slot][4]) begin
                        magic_hi[acc_slot] <= acc_wdata;
                    end
                end
                REG_ENABLE: begin
                    enable[acc_slot] <= acc_wdata & ENABLE_MASK;
                    if (acc_wdata[4]) begin  // Lock also closes SRAM
                        magic_lo[acc_slot] <= '0;
                        magic_hi[acc_slot] <= '0;
                    end
                end
                REG_BANK: bank[acc_slot] <= acc_wdata[1:0];
                default: ;
            endcase
        end
    end

    // Lines up with the memory read data one edge later
    always_ff @(posedge cpu_bus) begin
        if (acc_stb) begin
            reg_rdata <= rd_value;
        end
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            mem_sel <= 1'b0;
        end else begin
            mem_sel <= rom_rd || sram_rd;
        end
    end

endmodule

// ==== src/opll_port.sv ====
`timescale 1ns/100ps

module opll_port
    import fmpac_pkg::*;
(
    input  logic      cpu_bus,
    input  logic      rst_n,
    input  logic      opll_addr_wr,
    input  logic      opll_data_wr,
    input  cpu_data_t opll_value,
    output logic      opll_wr,
    output cpu_data_t opll_reg,
    output cpu_data_t opll_data
);

    cpu_data_t reg_latch;  // Last OPLL register index written

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            reg_latch <= '0;
        end else if (opll_addr_wr) begin
            reg_latch <= opll_value;
        end
    end

    // One strobe per data write, address writes stay silent
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            opll_wr <= 1'b0;
        end else begin
            opll_wr <= opll_data_wr;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (opll_data_wr) begin
            opll_reg  <= reg_latch;
            opll_data <= opll_value;
        end
    end

endmodule

// ==== src/cart_memory.sv ====
`timescale 1ns/100ps

module cart_memory
    import fmpac_pkg::*;
#(
    parameter int  NUM_SLOTS = 2,
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic              cpu_bus,
    input  logic              rst_n,
    input  logic              load_we,
    input  rom_addr_t         load_addr,
    input  cpu_data_t         load_data,
    input  logic              rom_rd,
    input  rom_addr_t         rom_addr,
    input  logic              sram_rd,
    input  logic              sram_wr,
    input  sram_addr_t        sram_addr,
    input  cpu_data_t         sram_wdata,
    input  logic [SLOT_W-1:0] sram_slot,
    output cpu_data_t         mem_rdata,
    output logic              mem_valid
);

    localparam int ROM_DEPTH  = 2 ** $bits(rom_addr_t);        // 64 KB, four banks
    localparam int SRAM_DEPTH = NUM_SLOTS * (2 ** SRAM_BITS);

    cpu_data_t rom  [ROM_DEPTH];
    cpu_data_t sram [SRAM_DEPTH];

    logic [SLOT_W+SRAM_BITS-1:0] sram_index;

    assign sram_index = {sram_slot, sram_addr};  // Slot picks the 8 KB block

    // ROM image comes only from the downloader
    always_ff @(posedge cpu_bus) begin
        if (load_we) begin
            rom[load_addr] <= load_data;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (sram_wr) begin
            sram[sram_index] <= sram_wdata;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (rom_rd) begin
            mem_rdata <= rom[rom_addr];
        end else if (sram_rd) begin
            mem_rdata <= sram[sram_index];
        end
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= rom_rd || sram_rd;  // High for one cycle per read
        end
    end

endmodule

// ==== src/fmpac_cart.sv ====
`timescale 1ns/100ps

module fmpac_cart
    import fmpac_pkg::*;
#(
    parameter int  NUM_SLOTS = 2,
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic              cpu_bus,
    input  logic              rst_n,
    input  logic              req,
    input  cpu_addr_t         addr,
    input  cpu_data_t         wdata,
    input  logic              wr,
    input  logic [SLOT_W-1:0] slot_id,
    output logic              ack,
    output cpu_data_t         rdata,
    input  logic              load_we,
    input  rom_addr_t         load_addr,
    input  cpu_data_t         load_data,
    output logic              opll_wr,
    output cpu_data_t         opll_reg,
    output cpu_data_t         opll_data
);

    logic              acc_stb;
    cpu_addr_t         acc_addr;
    cpu_data_t         acc_wdata;
    logic              acc_wr;
    logic [SLOT_W-1:0] acc_slot;

    logic              rom_rd;
    rom_addr_t         rom_addr;
    logic              sram_rd;
    logic              sram_wr;
    sram_addr_t        sram_addr;
    cpu_data_t         sram_wdata;
    logic [SLOT_W-1:0] sram_slot;

    logic              opll_addr_wr;
    logic              opll_data_wr;
    cpu_data_t         opll_value;

    cpu_data_t         reg_rdata;
    cpu_data_t         mem_rdata;
    logic              mem_valid;

    cpu_bus_slave #(
        .NUM_SLOTS (NUM_SLOTS)
    ) cpu_bus_slave_inst (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .wr        (wr),
        .slot_id   (slot_id),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid),
        .reg_rdata (reg_rdata),
        .ack       (ack),
        .rdata     (rdata),
        .acc_stb   (acc_stb),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .acc_wr    (acc_wr),
        .acc_slot  (acc_slot)
    );

    fmpac_mapper #(
        .NUM_SLOTS (NUM_SLOTS)
    ) fmpac_mapper_inst (
        .cpu_bus      (cpu_bus),
        .rst_n        (rst_n),
        .acc_stb      (acc_stb),
        .acc_addr     (acc_addr),
        .acc_wdata    (acc_wdata),
        .acc_wr       (acc_wr),
        .acc_slot     (acc_slot),
        .rom_rd       (rom_rd),
        .rom_addr     (rom_addr),
        .sram_rd      (sram_rd),
        .sram_wr      (sram_wr),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata),
        .sram_slot    (sram_slot),
        .opll_addr_wr (opll_addr_wr),
        .opll_data_wr (opll_data_wr),
        .opll_value   (opll_value),
        .reg_rdata    (reg_rdata),
        .mem_sel      ()
    );

    cart_memory #(
        .NUM_SLOTS (NUM_SLOTS)
    ) cart_memory_inst (
        .cpu_bus    (cpu_bus),
        .rst_n      (rst_n),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rom_rd     (rom_rd),
        .rom_addr   (rom_addr),
        .sram_rd    (sram_rd),
        .sram_wr    (sram_wr),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_slot  (sram_slot),
        .mem_rdata  (mem_rdata),
        .mem_valid  (mem_valid)
    );

    opll_port opll_port_inst (
        .cpu_bus      (cpu_bus),
        .rst_n        (rst_n),
        .opll_addr_wr (opll_addr_wr),
        .opll_data_wr (opll_data_wr),
        .opll_value   (opll_value),
        .opll_wr      (opll_wr),
        .opll_reg     (opll_reg),
        .opll_data    (opll_data)
    );

endmodule

// ==== sim/fmpac_cart_sva.sv ====
`timescale 1ns/100ps

module cpu_bus_slave_sva (
    input logic cpu_bus,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic acc_stb
);

    // ack only answers a req seen on the edge before
    ack_needs_req: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    ack_held: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    stb_single: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        acc_stb |=> !acc_stb)
        else $error("acc_stb lasted longer than one cycle");

endmodule

bind cpu_bus_slave cpu_bus_slave_sva cpu_bus_slave_sva_inst (
    .cpu_bus (cpu_bus),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .acc_stb (acc_stb)
);

// ==== sim/fmpac_cart_tb.sv ====
`timescale 1ns/100ps

module fmpac_cart_tb
    import fmpac_pkg::*;
();

    localparam int NUM_SLOTS      = 2;
    localparam int ROM_BYTES      = 65536;
    localparam int RESET_CYCLES   = 10;
    localparam int ACCESS_BUDGET  = 120;  // Upper bound on bus accesses below
    localparam int ACCESS_CYCLES  = 6;    // Drive, three edges to ack, release, idle
    localparam int TIMEOUT_CYCLES =
        4 * (RESET_CYCLES + ROM_BYTES + ACCESS_BUDGET * ACCESS_CYCLES);

    // Register addresses as the CPU sees them in page 1
    localparam cpu_addr_t MAGIC_LO_ADDR  = {2'b01, REG_MAGIC_LO};
    localparam cpu_addr_t MAGIC_HI_ADDR  = {2'b01, REG_MAGIC_HI};
    localparam cpu_addr_t OPLL_ADDR_ADDR = {2'b01, REG_OPLL_ADDR};
    localparam cpu_addr_t OPLL_DATA_ADDR = {2'b01, REG_OPLL_DATA};
    localparam cpu_addr_t ENABLE_ADDR    = {2'b01, REG_ENABLE};
    localparam cpu_addr_t BANK_ADDR      = {2'b01, REG_BANK};

    logic      cpu_bus;
    logic      rst_n;
    logic      req;
    cpu_addr_t addr;
    cpu_data_t wdata;
    logic      wr;
    logic      slot_id;
    logic      ack;
    cpu_data_t rdata;
    logic      load_we;
    rom_addr_t load_addr;
    cpu_data_t load_data;
    logic      opll_wr;
    cpu_data_t opll_reg;
    cpu_data_t opll_data;

    integer seed   = 226;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    // Reference model of ROM, SRAM and mapper registers
    cpu_data_t ref_rom      [ROM_BYTES];
    cpu_data_t ref_sram     [NUM_SLOTS][2 ** SRAM_BITS];
    cpu_data_t ref_enable   [NUM_SLOTS];
    bank_t     ref_bank     [NUM_SLOTS];
    cpu_data_t ref_magic_lo [NUM_SLOTS];
    cpu_data_t ref_magic_hi [NUM_SLOTS];
    cpu_data_t ref_opll_reg;

    logic [8:0]  read_q [$];  // Check flag on top of the expected rdata
    logic [15:0] opll_q [$];  // OPLL register then data
    logic [8:0]  read_item;
    logic [15:0] opll_item;
    logic        ack_seen = 1'b0;

    cpu_addr_t sram_addrs [4] = '{16'h4000, 16'h4123, 16'h5000, 16'h5FFD};

    fmpac_cart #(
        .NUM_SLOTS (NUM_SLOTS)
    ) fmpac_cart_inst (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .wr        (wr),
        .slot_id   (slot_id),
        .ack       (ack),
        .rdata     (rdata),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .opll_wr   (opll_wr),
        .opll_reg  (opll_reg),
        .opll_data (opll_data)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #50 cpu_bus = ~cpu_bus;
    end

    task automatic compare_value(string name, int expected, int actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAIL time=%0t %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Expected read byte, from the mapper decode rules
    function automatic cpu_data_t expected_read(int slot, cpu_addr_t a);
        logic [PAGE_BITS-1:0] off;
        logic                 unlocked;
        off      = a[PAGE_BITS-1:0];
        unlocked = ({ref_magic_hi[slot], ref_magic_lo[slot]} == SRAM_MAGIC);
        if (a[15:14] != 2'b01) begin
            return OPEN_BUS;
        end else if (unlocked && off < REG_MAGIC_LO) begin
            return ref_sram[slot][off[SRAM_BITS-1:0]];
        end else if (off == REG_ENABLE) begin
            return ref_enable[slot];
        end else if (off == REG_BANK) begin
            return {6'b000000, ref_bank[slot]};
        end else if (unlocked && off == REG_MAGIC_LO) begin
            return ref_magic_lo[slot];
        end else if (unlocked && off == REG_MAGIC_HI) begin
            return ref_magic_hi[slot];
        end
        return ref_rom[{ref_bank[slot], off}];
    endfunction

    task automatic model_write(int slot, cpu_addr_t a, cpu_data_t d);
        logic [PAGE_BITS-1:0] off;
        logic                 unlocked;
        off      = a[PAGE_BITS-1:0];
        unlocked = ({ref_magic_hi[slot], ref_magic_lo[slot]} == SRAM_MAGIC);
        if (a[15:14] != 2'b01) begin
            return;  // Nothing decoded outside page 1
        end
        if (unlocked && off < REG_MAGIC_LO) begin
            ref_sram[slot][off[SRAM_BITS-1:0]] = d;
        end else if (off == REG_MAGIC_LO && !ref_enable[slot][4]) begin
            ref_magic_lo[slot] = d;
        end else if (off == REG_MAGIC_HI && !ref_enable[slot][4]) begin
            ref_magic_hi[slot] = d;
        end else if (off == REG_ENABLE) begin
            ref_enable[slot] = d & ENABLE_MASK;
            if (d[4]) begin
                ref_magic_lo[slot] = 8'h00;
                ref_magic_hi[slot] = 8'h00;
            end
        end else if (off == REG_BANK) begin
            ref_bank[slot] = d[1:0];
        end else if (off == REG_OPLL_ADDR && ref_enable[slot][0]) begin
            ref_opll_reg = d;
        end else if (off == REG_OPLL_DATA && ref_enable[slot][0]) begin
            opll_q.push_back({ref_opll_reg, d});
        end
    endtask

    // One four-phase access, with ack timing checked against req
    task automatic bus_access(int slot, cpu_addr_t a, logic is_write, cpu_data_t d);
        int wait_cycles;
        if (is_write) begin
            read_q.push_back({1'b0, 8'h00});
            model_write(slot, a, d);
        end else begin
            read_q.push_back({1'b1, expected_read(slot, a)});
        end
        @(negedge cpu_bus);
        addr    = a;
        wdata   = d;
        wr      = is_write;
        slot_id = 1'(slot);
        req     = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge cpu_bus);
            wait_cycles++;
        end while (!ack);
        compare_value("ack latency", 3, wait_cycles);
        req = 1'b0;
        @(negedge cpu_bus);
        compare_value("ack", 0, int'(ack));  // One edge after release
    endtask

    task automatic bus_write(int slot, cpu_addr_t a, cpu_data_t d);
        bus_access(slot, a, 1'b1, d);
    endtask

    task automatic bus_read(int slot, cpu_addr_t a);
        bus_access(slot, a, 1'b0, 8'h00);
    endtask

    function automatic cpu_addr_t random_page1_addr();
        return {2'b01, 14'($random(seed))};
    endfunction

    task automatic load_rom();
        for (int i = 0; i < ROM_BYTES; i++) begin
            @(negedge cpu_bus);
            load_we   = 1'b1;
            load_addr = rom_addr_t'(i);
            load_data = cpu_data_t'($random(seed));
            ref_rom[i] = load_data;
        end
        @(negedge cpu_bus);
        load_we = 1'b0;
    endtask

    // Response checks, sampled on the falling edge
    always @(negedge cpu_bus) begin
        if (ack && !ack_seen) begin
            if (read_q.size() == 0) begin
                $display("ERROR: ack raised with no access pending at %0t", $time);
                errors++;
            end else begin
                read_item = read_q.pop_front();
                if (read_item[8]) begin
                    compare_value("rdata", int'(read_item[7:0]), int'(rdata));
                end
            end
        end
        ack_seen = ack;
        if (opll_wr) begin
            if (opll_q.size() == 0) begin
                $display("ERROR: opll_wr pulsed for a write that must not pass at %0t", $time);
                errors++;
            end else begin
                opll_item = opll_q.pop_front();
                compare_value("opll_reg", int'(opll_item[15:8]), int'(opll_reg));
                compare_value("opll_data", int'(opll_item[7:0]), int'(opll_data));
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge cpu_bus);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        addr      = '0;
        wdata     = '0;
        wr        = 1'b0;
        slot_id   = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        ref_opll_reg = 8'h00;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            ref_enable[s]   = 8'h00;
            ref_bank[s]     = 2'b00;
            ref_magic_lo[s] = 8'h00;
            ref_magic_hi[s] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge cpu_bus);
        @(negedge cpu_bus);
        rst_n = 1'b1;
        compare_value("ack", 0, int'(ack));
        compare_value("opll_wr", 0, int'(opll_wr));
        load_rom();

        // All four banks on slot 0, upper bank bits ignored
        for (int b = 0; b < 4; b++) begin
            bus_write(0, BANK_ADDR, cpu_data_t'(8'hFC | b));
            bus_read(0, 16'h4000);
            repeat (3) bus_read(0, random_page1_addr());
        end
        bus_write(0, BANK_ADDR, 8'h01);
        bus_write(1, BANK_ADDR, 8'h02);
        bus_read(0, 16'h5234);
        bus_read(1, 16'h5234);
        bus_read(0, BANK_ADDR);
        bus_read(1, BANK_ADDR);

        // SRAM unlock and per-slot contents
        for (int s = 0; s < NUM_SLOTS; s++) begin
            bus_write(s, MAGIC_LO_ADDR, SRAM_MAGIC[7:0]);
            bus_write(s, MAGIC_HI_ADDR, SRAM_MAGIC[15:8]);
            foreach (sram_addrs[k]) bus_write(s, sram_addrs[k], cpu_data_t'($random(seed)));
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            foreach (sram_addrs[k]) bus_read(s, sram_addrs[k]);
            bus_read(s, MAGIC_LO_ADDR);
            bus_read(s, MAGIC_HI_ADDR);
        end
        bus_write(1, MAGIC_LO_ADDR, 8'h00);  // Wrong magic, back to ROM
        foreach (sram_addrs[k]) bus_read(1, sram_addrs[k]);
        bus_read(1, MAGIC_LO_ADDR);
        bus_read(1, MAGIC_HI_ADDR);

        // Lock bit closes SRAM and blocks magic writes
        bus_write(0, ENABLE_ADDR, 8'hFF);
        bus_read(0, ENABLE_ADDR);
        bus_read(0, sram_addrs[1]);
        bus_write(0, MAGIC_LO_ADDR, SRAM_MAGIC[7:0]);
        bus_write(0, MAGIC_HI_ADDR, SRAM_MAGIC[15:8]);
        bus_read(0, sram_addrs[1]);
        bus_write(0, ENABLE_ADDR, 8'h01);
        bus_write(0, MAGIC_LO_ADDR, SRAM_MAGIC[7:0]);
        bus_write(0, MAGIC_HI_ADDR, SRAM_MAGIC[15:8]);
        bus_read(0, sram_addrs[1]);

        // OPLL forwarding with enable bit 0 set on slot 0 only
        repeat (2) begin
            bus_write(0, OPLL_ADDR_ADDR, cpu_data_t'($random(seed)));
            bus_write(0, OPLL_DATA_ADDR, cpu_data_t'($random(seed)));
        end
        bus_write(1, ENABLE_ADDR, 8'h00);
        bus_write(1, OPLL_ADDR_ADDR, 8'h30);
        bus_write(1, OPLL_DATA_ADDR, 8'h55);
        bus_write(0, OPLL_DATA_ADDR, cpu_data_t'($random(seed)));

        // Open bus and register readback
        bus_write(1, ENABLE_ADDR, 8'hE1);
        bus_read(0, 16'h0000);
        bus_read(1, 16'h3FFF);
        bus_read(0, 16'h8000);
        bus_read(1, 16'hC123);
        bus_read(0, ENABLE_ADDR);
        bus_read(1, ENABLE_ADDR);
        bus_read(0, BANK_ADDR);
        bus_read(1, BANK_ADDR);

        repeat (4) @(negedge cpu_bus);
        if (opll_q.size() != 0) begin
            $display("ERROR: %0d expected OPLL write strobes never appeared", opll_q.size());
            errors++;
        end
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== fmpac_cart.f ====
src/fmpac_pkg.sv
src/cpu_bus_slave.sv
src/fmpac_mapper.sv
src/opll_port.sv
src/cart_memory.sv
src/fmpac_cart.sv
sim/fmpac_cart_sva.sv
sim/fmpac_cart_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fmpac_cart_tb
FILELIST  = fmpac_cart.f
OBJDIR    = obj_dir
PASS_MSG  = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
